//--- filelist.f
rtl/glb_pkg.sv
rtl/glb_shift.sv
rtl/glb_core_store_dma.sv
rtl/glb_bank.sv
rtl/glb_store_tile.sv
tb/tb_glb_store.sv

//--- rtl/glb_bank.sv
// Bank memory of the tile, 64-bit words with byte strobes.
// The write port takes the store DMA packet; the read port has one cycle
// of latency and serves the load side.

module glb_bank (
    input  logic                                    clk,
    input  logic                                    clk_en,
    input  logic                                    reset,
    input  glb_pkg::wr_packet_t                     wr_packet,
    input  logic                                    rd_en,
    input  logic [glb_pkg::glb_addr_width-1:0]      rd_addr,
    output logic [glb_pkg::bank_data_width-1:0]     rd_data
);

    localparam int word_addr_w = glb_pkg::glb_addr_width - glb_pkg::bank_byte_offset;
    localparam int bank_depth  = 1 << word_addr_w;
    localparam int num_bytes   = glb_pkg::bank_data_width / 8;

    logic [glb_pkg::bank_data_width-1:0] mem [bank_depth];

    logic [word_addr_w-1:0] wr_word, rd_word;

    assign wr_word = wr_packet.wr_addr[glb_pkg::glb_addr_width-1:glb_pkg::bank_byte_offset];
    assign rd_word = rd_addr[glb_pkg::glb_addr_width-1:glb_pkg::bank_byte_offset];

    // per-byte write under strobe
    always_ff @(posedge clk) begin
        if (clk_en && wr_packet.wr_en) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (wr_packet.wr_strb[b]) begin
                    mem[wr_word][b*8 +: 8] <= wr_packet.wr_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end
        else if (clk_en && rd_en) begin
            rd_data <= mem[rd_word];
        end
    end

    a_wr_aligned: assert property (@(posedge clk) disable iff (reset)
        wr_packet.wr_en |-> (wr_packet.wr_addr[glb_pkg::bank_byte_offset-1:0] == '0));

endmodule

//--- rtl/glb_core_store_dma.sv
// Store DMA of one global-buffer tile.
// Captures headers from the config registers, packs 16-bit stream words into
// 64-bit bank words with byte strobes and returns invalidate and done pulses.

module glb_core_store_dma #(
    parameter int queue_depth   = 4,
    parameter int num_glb_tiles = 8
) (
    input  logic                                        clk,
    input  logic                                        clk_en,
    input  logic                                        reset,
    input  logic [glb_pkg::cgra_data_width-1:0]         stream_data_f2g,
    input  logic                                        stream_data_valid_f2g,
    input  logic [1:0]                                  cfg_st_dma_mode,
    input  glb_pkg::dma_st_header_t [queue_depth-1:0]   cfg_st_dma_header,
    input  logic [glb_pkg::latency_width-1:0]           cfg_latency,
    output glb_pkg::wr_packet_t                         wr_packet,
    output logic [queue_depth-1:0]                      cfg_store_dma_invalidate_pulse,
    output logic                                        stream_f2g_done_pulse
);

    localparam int addr_w     = glb_pkg::glb_addr_width;
    localparam int word_w     = glb_pkg::cgra_data_width;
    localparam int word_bytes = glb_pkg::cgra_data_width / 8;
    localparam int q_sel_w    = (queue_depth > 1) ? $clog2(queue_depth) : 1;

    typedef enum logic [2:0] {off, idle, ready, acc1, acc2, acc3, acc4, done} state_t;

    state_t state, next_state;

    logic dma_on, auto_on;

    logic [queue_depth-1:0]                     hdr_valid_in, hdr_valid_d1, hdr_rise;
    glb_pkg::dma_st_header_t [queue_depth-1:0]  hdr_q;
    glb_pkg::dma_st_header_t                    sel_hdr;
    logic [q_sel_w-1:0]                         q_sel_r, q_sel;
    logic                                       take;

    logic [glb_pkg::bank_data_width-1:0]        cache_data, next_cache_data;
    logic [glb_pkg::bank_data_width/8-1:0]      cache_strb, next_cache_strb;
    logic [addr_w-1:0]                          cur_addr, next_cur_addr;
    logic [glb_pkg::max_num_words_width-1:0]    num_cnt, next_num_cnt;
    logic                                       is_first_word, next_is_first_word;
    logic [1:0]                                 lane;

    logic                                       wr_full, wr_last;
    logic                                       done_rise;
    logic [num_glb_tiles-1:0][0:0]              done_shift;

    // 00 off, 01/10 manual on slot 0, 11 auto round-robin
    assign dma_on  = (cfg_st_dma_mode != 2'b00);
    assign auto_on = (cfg_st_dma_mode == 2'b11);

    // header capture on rising valid
    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            hdr_valid_in[i] = cfg_st_dma_header[i].valid;
        end
    end

    assign hdr_rise = hdr_valid_in & ~hdr_valid_d1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_valid_d1 <= '0;
            hdr_q        <= '0;
        end
        else if (clk_en) begin
            hdr_valid_d1 <= hdr_valid_in;
            for (int i = 0; i < queue_depth; i++) begin
                if (hdr_rise[i]) begin
                    hdr_q[i] <= cfg_st_dma_header[i];
                end
                else if (cfg_store_dma_invalidate_pulse[i]) begin
                    hdr_q[i].valid <= 1'b0;
                end
            end
        end
    end

    // queue select is zero outside auto mode
    assign q_sel   = auto_on ? q_sel_r : '0;
    assign sel_hdr = hdr_q[q_sel];
    assign take    = dma_on && (state == idle) && sel_hdr.valid && (sel_hdr.num_words != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel_r                        <= '0;
            cfg_store_dma_invalidate_pulse <= '0;
        end
        else if (clk_en) begin
            if (!auto_on) begin
                q_sel_r <= '0;
            end
            else if (take) begin
                // wraps by itself since the depth is a power of two
                q_sel_r <= q_sel_r + 1'b1;
            end
            for (int i = 0; i < queue_depth; i++) begin
                cfg_store_dma_invalidate_pulse[i] <= take && (q_sel == q_sel_w'(i));
            end
        end
    end

    // lane written by the word accepted in each packing state
    always_comb begin
        case (state)
            acc1:    lane = 2'd1;
            acc2:    lane = 2'd2;
            acc3:    lane = 2'd3;
            default: lane = 2'd0;
        endcase
    end

    always_comb begin
        next_state         = state;
        next_cache_data    = cache_data;
        next_cache_strb    = cache_strb;
        next_cur_addr      = cur_addr;
        next_num_cnt       = num_cnt;
        next_is_first_word = is_first_word;
        case (state)
            off: begin
                if (dma_on) begin
                    next_state = idle;
                end
            end
            idle: begin
                // drop anything left by an abandoned transfer
                next_cache_data = '0;
                next_cache_strb = '0;
                next_num_cnt    = '0;
                if (take) begin
                    next_cur_addr      = {sel_hdr.start_addr[addr_w-1:1], 1'b0};
                    next_num_cnt       = sel_hdr.num_words;
                    next_is_first_word = 1'b1;
                    case (sel_hdr.start_addr[2:1])
                        2'd0:    next_state = ready;
                        2'd1:    next_state = acc1;
                        2'd2:    next_state = acc2;
                        default: next_state = acc3;
                    endcase
                end
            end
            ready, acc1, acc2, acc3, acc4: begin
                if (num_cnt == '0) begin
                    next_state = done;
                end
                else if (stream_data_valid_f2g) begin
                    // full word leaves this cycle so start a fresh one
                    if (state == acc4) begin
                        next_cache_data = '0;
                        next_cache_strb = '0;
                    end
                    next_cache_data[lane*word_w +: word_w]         = stream_data_f2g;
                    next_cache_strb[lane*word_bytes +: word_bytes] = '1;
                    next_num_cnt       = num_cnt - 1'b1;
                    next_is_first_word = 1'b0;
                    if (!is_first_word) begin
                        next_cur_addr = cur_addr + addr_w'(word_bytes);
                    end
                    case (lane)
                        2'd0:    next_state = acc1;
                        2'd1:    next_state = acc2;
                        2'd2:    next_state = acc3;
                        default: next_state = acc4;
                    endcase
                end
                else if (state == acc4) begin
                    next_cache_data = '0;
                    next_cache_strb = '0;
                    next_state      = ready;
                end
            end
            done: begin
                next_cache_data = '0;
                next_cache_strb = '0;
                next_num_cnt    = '0;
                next_state      = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= off;
            cache_data    <= '0;
            cache_strb    <= '0;
            cur_addr      <= '0;
            num_cnt       <= '0;
            is_first_word <= 1'b0;
        end
        else if (clk_en) begin
            state         <= dma_on ? next_state : off;
            cache_data    <= next_cache_data;
            cache_strb    <= next_cache_strb;
            cur_addr      <= next_cur_addr;
            num_cnt       <= next_num_cnt;
            is_first_word <= next_is_first_word;
        end
    end

    // full word in the cycle after lane 3 and the last word on done
    assign wr_full = (state == acc4) && (num_cnt != '0);
    assign wr_last = (state == done);

    always_comb begin
        wr_packet.wr_en   = wr_full || wr_last;
        wr_packet.wr_strb = wr_packet.wr_en ? cache_strb : '0;
        wr_packet.wr_data = wr_packet.wr_en ? cache_data : '0;
        wr_packet.wr_addr = '0;
        if (wr_packet.wr_en) begin
            wr_packet.wr_addr = {cur_addr[addr_w-1:glb_pkg::bank_byte_offset],
                                 {glb_pkg::bank_byte_offset{1'b0}}};
        end
    end

    // the done state lasts one enabled cycle and is its own rising edge
    assign done_rise = (state == done);

    // done pulse delayed along the tile chain
    glb_shift #(
        .data_width (1),
        .depth      (num_glb_tiles)
    ) u_done_shift (
        .clk      (clk),
        .clk_en   (clk_en),
        .reset    (reset),
        .data_in  (done_rise),
        .data_out (done_shift)
    );

    assign stream_f2g_done_pulse = done_shift[cfg_latency];

    a_wr_strb: assert property (@(posedge clk) disable iff (reset)
        wr_packet.wr_en |-> (wr_packet.wr_strb != '0));

    a_inv_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (clk_en && (|cfg_store_dma_invalidate_pulse)) |=>
        (cfg_store_dma_invalidate_pulse == '0));

    a_latency: assert property (@(posedge clk) disable iff (reset)
        cfg_latency < num_glb_tiles);

endmodule

//--- rtl/glb_pkg.sv
// Shared widths and packet types for the global-buffer store tile.
// Modules refer to these by scoped name; nothing here holds logic.

package glb_pkg;

    // stream and bank word widths
    localparam int cgra_data_width = 16;
    localparam int bank_data_width = 64;

    // address bits inside one bank word
    localparam int bank_byte_offset = 3;

    // byte address of the tile bank, 128 bank words
    localparam int glb_addr_width = 10;

    // header word count
    localparam int max_num_words_width = 10;

    // tile-chain latency select
    localparam int latency_width = 4;

    // one store DMA header slot
    // start_addr bit 0 is ignored, words are 16-bit aligned
    typedef struct packed {
        logic                           valid;
        logic [glb_addr_width-1:0]      start_addr;
        logic [max_num_words_width-1:0] num_words;
    } dma_st_header_t;

    // bank write request
    // wr_addr is always aligned to a bank word
    typedef struct packed {
        logic                           wr_en;
        logic [bank_data_width/8-1:0]   wr_strb;
        logic [glb_addr_width-1:0]      wr_addr;
        logic [bank_data_width-1:0]     wr_data;
    } wr_packet_t;

endpackage

//--- rtl/glb_shift.sv
// Clock-enabled shift chain with every stage visible.
// Stage k holds data_in delayed by k+1 enabled cycles, so the caller can
// pick a runtime delay by indexing data_out.

module glb_shift #(
    parameter int data_width = 1,
    parameter int depth      = 8
) (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                reset,
    input  logic [data_width-1:0]               data_in,
    output logic [depth-1:0][data_width-1:0]    data_out
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_out <= '0;
        end
        else if (clk_en) begin
            data_out[0] <= data_in;
            // each stage takes the one before it
            for (int i = 1; i < depth; i++) begin
                data_out[i] <= data_out[i-1];
            end
        end
    end

endmodule

//--- rtl/glb_store_tile.sv
// Store path of one global-buffer tile.
// Joins the store DMA to the bank memory; the queue depth and the
// tile-chain length are set here and passed down.

module glb_store_tile #(
    parameter int queue_depth   = 4,
    parameter int num_glb_tiles = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        clk_en,
    input  logic [glb_pkg::cgra_data_width-1:0]         stream_data,
    input  logic                                        stream_data_valid,
    input  logic [1:0]                                  cfg_st_dma_mode,
    input  glb_pkg::dma_st_header_t [queue_depth-1:0]   cfg_st_dma_header,
    input  logic [glb_pkg::latency_width-1:0]           cfg_latency,
    input  logic                                        rd_en,
    input  logic [glb_pkg::glb_addr_width-1:0]          rd_addr,
    output logic [glb_pkg::bank_data_width-1:0]         rd_data,
    output logic [queue_depth-1:0]                      cfg_store_dma_invalidate_pulse,
    output logic                                        stream_f2g_done_pulse
);

    // DMA to bank write path
    glb_pkg::wr_packet_t wr_packet;

    glb_core_store_dma #(
        .queue_depth   (queue_depth),
        .num_glb_tiles (num_glb_tiles)
    ) u_store_dma (
        .clk                            (clk),
        .clk_en                         (clk_en),
        .reset                          (reset),
        .stream_data_f2g                (stream_data),
        .stream_data_valid_f2g          (stream_data_valid),
        .cfg_st_dma_mode                (cfg_st_dma_mode),
        .cfg_st_dma_header              (cfg_st_dma_header),
        .cfg_latency                    (cfg_latency),
        .wr_packet                      (wr_packet),
        .cfg_store_dma_invalidate_pulse (cfg_store_dma_invalidate_pulse),
        .stream_f2g_done_pulse          (stream_f2g_done_pulse)
    );

    glb_bank u_bank (
        .clk       (clk),
        .clk_en    (clk_en),
        .reset     (reset),
        .wr_packet (wr_packet),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the store tile testbench with Verilator, runs it into a log
# and decides pass or fail from that log.

set -u
cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_glb_store --Mdir "$obj_dir" -o tb_glb_store_sim \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/tb_glb_store_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" "$log_file"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1

//--- tb/tb_glb_store.sv
// Testbench for the global-buffer store tile.
// Streams words through the store DMA, reads the bank back and compares it
// with a byte-image reference; monitors watch the invalidate and done pulses.

module tb_glb_store;

    localparam int queue_depth   = 4;
    localparam int num_glb_tiles = 8;
    localparam int addr_w        = glb_pkg::glb_addr_width;
    localparam int off_w         = glb_pkg::bank_byte_offset;
    localparam int num_w         = glb_pkg::max_num_words_width;
    localparam int word_w        = glb_pkg::cgra_data_width;

    logic                                       clk = 1'b0;
    logic                                       reset;
    logic                                       clk_en;
    logic [glb_pkg::cgra_data_width-1:0]        stream_data;
    logic                                       stream_data_valid;
    logic                                       stream_last;
    logic [1:0]                                 cfg_st_dma_mode;
    glb_pkg::dma_st_header_t [queue_depth-1:0]  cfg_st_dma_header;
    logic [glb_pkg::latency_width-1:0]          cfg_latency;
    logic                                       rd_en;
    logic [addr_w-1:0]                          rd_addr;
    logic [glb_pkg::bank_data_width-1:0]        rd_data;
    logic [queue_depth-1:0]                     inv_pulse;
    logic                                       done_pulse;

    int error_count = 0;
    int test_count  = 0;
    int errs_base   = 0;
    int done_count  = 0;
    int done_expect = 0;
    int since_last  = 1000;
    int inv_count [queue_depth];
    int inv_expect [queue_depth];
    bit armed;
    bit edge_en;
    bit rd_pend;

    logic [addr_w-off_w-1:0]                    rd_word_q;
    logic [7:0]                                 mirror [1 << addr_w];
    bit                                         known [1 << addr_w];
    logic [glb_pkg::cgra_data_width-1:0]        words [256];

    glb_store_tile #(
        .queue_depth   (queue_depth),
        .num_glb_tiles (num_glb_tiles)
    ) dut (
        .clk                            (clk),
        .reset                          (reset),
        .clk_en                         (clk_en),
        .stream_data                    (stream_data),
        .stream_data_valid              (stream_data_valid),
        .cfg_st_dma_mode                (cfg_st_dma_mode),
        .cfg_st_dma_header              (cfg_st_dma_header),
        .cfg_latency                    (cfg_latency),
        .rd_en                          (rd_en),
        .rd_addr                        (rd_addr),
        .rd_data                        (rd_data),
        .cfg_store_dma_invalidate_pulse (inv_pulse),
        .stream_f2g_done_pulse          (done_pulse)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("error at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // expected byte image of one transfer with the low byte of each word first
    function automatic void apply_reference(input logic [addr_w-1:0] start, input int n);
        logic [addr_w-1:0] a;
        for (int k = 0; k < n; k++) begin
            a = {start[addr_w-1:1], 1'b0} + addr_w'(2 * k);
            mirror[a]     = words[k][7:0];
            mirror[a + 1] = words[k][15:8];
            known[a]      = 1'b1;
            known[a + 1]  = 1'b1;
        end
    endfunction

    // sampled edge info for the monitors and the read compare
    always @(posedge clk) begin
        edge_en   <= clk_en && !reset;
        rd_pend   <= rd_en && clk_en && !reset;
        rd_word_q <= rd_addr[addr_w-1:off_w];
        if (!reset && clk_en) begin
            if (stream_data_valid && stream_last) begin
                since_last <= 0;
                armed      <= 1'b1;
            end
            else begin
                since_last <= since_last + 1;
            end
        end
    end

    // invalidate pulses per slot counted once per enabled cycle
    always @(negedge clk) begin
        if (!reset && edge_en) begin
            for (int s = 0; s < queue_depth; s++) begin
                if (inv_pulse[s]) begin
                    inv_count[s]++;
                end
            end
        end
    end

    // done pulse must sit exactly latency+2 enabled edges after the last word
    always @(negedge clk) begin
        logic expect_pulse;
        if (!reset && edge_en) begin
            expect_pulse = armed && (since_last == int'(cfg_latency) + 2);
            check("stream_f2g_done_pulse", 64'(expect_pulse), 64'(done_pulse));
            if (done_pulse) begin
                done_count++;
            end
        end
    end

    // read data compare against the mirror on known bytes only
    always @(negedge clk) begin
        logic [addr_w-1:0] ba;
        if (rd_pend) begin
            for (int b = 0; b < 8; b++) begin
                ba = {rd_word_q, off_w'(b)};
                if (known[ba]) begin
                    check($sformatf("rd_data byte 0x%03h", ba), 64'(mirror[ba]),
                          64'(rd_data[b*8 +: 8]));
                end
            end
        end
    end

    task automatic make_words(input int n);
        for (int i = 0; i < n; i++) begin
            words[i] = word_w'($urandom);
        end
    endtask

    task automatic set_header(input int slot, input logic [addr_w-1:0] start, input int n);
        cfg_st_dma_header[slot].start_addr <= start;
        cfg_st_dma_header[slot].num_words  <= num_w'(n);
        cfg_st_dma_header[slot].valid      <= 1'b1;
    endtask

    // one cycle of valid is enough for the rise detect
    task automatic drop_valids();
        @(posedge clk);
        for (int s = 0; s < queue_depth; s++) begin
            cfg_st_dma_header[s].valid <= 1'b0;
        end
    endtask

    task automatic raise_header(input int slot, input logic [addr_w-1:0] start, input int n);
        set_header(slot, start, n);
        drop_valids();
    endtask

    task automatic send_words(input int n, input bit jitter, input bit mark_last);
        int gap;
        bit en;
        for (int i = 0; i < n; i++) begin
            gap = jitter ? int'($urandom_range(3, 0)) : 0;
            // gap cycles either drop valid or hold clk_en low with junk on the bus
            repeat (gap) begin
                en = ($urandom_range(1, 0) == 1);
                clk_en            <= en;
                stream_data_valid <= !en;
                stream_data       <= word_w'($urandom);
                stream_last       <= 1'b0;
                @(posedge clk);
            end
            clk_en            <= 1'b1;
            stream_data       <= words[i];
            stream_data_valid <= 1'b1;
            stream_last       <= mark_last && (i == n - 1);
            @(posedge clk);
        end
        stream_data_valid <= 1'b0;
        stream_last       <= 1'b0;
    endtask

    task automatic wait_invalidate(input int slot, input int target);
        int n;
        n = 0;
        while (inv_count[slot] < target && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (inv_count[slot] < target) begin
            error_count++;
            $display("timed out waiting for the invalidate pulse of slot %0d", slot);
        end
    endtask

    task automatic wait_done(input int target, input int limit, output bit seen);
        int n;
        n = 0;
        while (done_count < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        seen = (done_count >= target);
    endtask

    task automatic read_region(input logic [addr_w-1:0] start, input int n);
        int first_w;
        int last_w;
        first_w = int'(start) >> off_w;
        last_w  = (int'({start[addr_w-1:1], 1'b0}) + 2 * n - 1) >> off_w;
        for (int w = first_w; w <= last_w; w++) begin
            rd_en   <= 1'b1;
            rd_addr <= addr_w'(w << off_w);
            @(posedge clk);
        end
        rd_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic stream_and_check(input int slot, input logic [addr_w-1:0] start,
                                    input int n, input bit jitter);
        int exp_total;
        int got_total;
        bit seen;
        exp_total = 0;
        got_total = 0;
        inv_expect[slot]++;
        wait_invalidate(slot, inv_expect[slot]);
        for (int s = 0; s < queue_depth; s++) begin
            exp_total += inv_expect[s];
            got_total += inv_count[s];
        end
        check("invalidate total", 64'(exp_total), 64'(got_total));
        send_words(n, jitter, 1'b1);
        done_expect++;
        wait_done(done_expect, 200, seen);
        if (!seen) begin
            error_count++;
            $display("timed out waiting for the done pulse of slot %0d", slot);
        end
        apply_reference(start, n);
        read_region(start, n);
    endtask

    task automatic end_test(input string name);
        for (int s = 0; s < queue_depth; s++) begin
            check($sformatf("invalidate count of slot %0d", s), 64'(inv_expect[s]),
                  64'(inv_count[s]));
        end
        check("done pulse count", 64'(done_expect), 64'(done_count));
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errs_base);
        errs_base = error_count;
    endtask

    initial begin
        bit seen;
        void'($urandom(33));
        reset             <= 1'b1;
        clk_en            <= 1'b1;
        stream_data       <= '0;
        stream_data_valid <= 1'b0;
        stream_last       <= 1'b0;
        cfg_st_dma_mode   <= 2'b00;
        cfg_st_dma_header <= '0;
        cfg_latency       <= '0;
        rd_en             <= 1'b0;
        rd_addr           <= '0;
        repeat (10) @(posedge clk);
        reset           <= 1'b0;
        cfg_st_dma_mode <= 2'b01;
        @(posedge clk);

        make_words(36);
        raise_header(0, 10'h000, 36);
        stream_and_check(0, 10'h000, 36, 1'b0);
        end_test("manual aligned");

        // partial words around bytes left from the first test
        make_words(5);
        raise_header(0, 10'h012, 5);
        stream_and_check(0, 10'h012, 5, 1'b0);
        make_words(3);
        raise_header(0, 10'h024, 3);
        stream_and_check(0, 10'h024, 3, 1'b0);
        make_words(6);
        raise_header(0, 10'h036, 6);
        stream_and_check(0, 10'h036, 6, 1'b0);
        end_test("unaligned starts");

        // same data once clean and once with gaps and stalls
        make_words(13);
        raise_header(0, 10'h200, 13);
        stream_and_check(0, 10'h200, 13, 1'b0);
        raise_header(0, 10'h240, 13);
        stream_and_check(0, 10'h240, 13, 1'b1);
        end_test("gaps and stalls");

        cfg_st_dma_mode <= 2'b11;
        @(posedge clk);
        set_header(0, 10'h080, 8);
        set_header(1, 10'h0c2, 7);
        set_header(2, 10'h104, 10);
        set_header(3, 10'h180, 0);
        drop_valids();
        make_words(8);
        stream_and_check(0, 10'h080, 8, 1'b0);
        make_words(7);
        stream_and_check(1, 10'h0c2, 7, 1'b0);
        make_words(10);
        stream_and_check(2, 10'h104, 10, 1'b0);
        repeat (20) @(posedge clk);
        end_test("auto round robin");

        cfg_st_dma_mode <= 2'b01;
        for (int i = 0; i < 3; i++) begin
            // let the previous pulse leave the whole chain first
            repeat (num_glb_tiles + 2) @(posedge clk);
            cfg_latency <= (i == 0) ? 4'd0 : (i == 1) ? 4'd3 : 4'd7;
            @(posedge clk);
            make_words(5 + i);
            raise_header(0, addr_w'(10'h140 + i * 32), 5 + i);
            stream_and_check(0, addr_w'(10'h140 + i * 32), 5 + i, 1'b0);
        end
        end_test("done latency");

        // three words only so no bank write happens before the abort
        make_words(10);
        raise_header(0, 10'h300, 10);
        inv_expect[0]++;
        wait_invalidate(0, inv_expect[0]);
        send_words(3, 1'b0, 1'b0);
        cfg_st_dma_mode <= 2'b00;
        @(posedge clk);
        wait_done(done_expect + 1, 40, seen);
        check("done pulse after mode off", 64'd0, 64'(seen));
        cfg_st_dma_mode <= 2'b01;
        @(posedge clk);
        make_words(9);
        raise_header(0, 10'h2c2, 9);
        stream_and_check(0, 10'h2c2, 9, 1'b0);
        end_test("mode off abort");

        $display("%0d errors in %0d tests", error_count, test_count);
        if (error_count == 0) begin
            $display("test passed");
        end
        else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
